/* Makefile */
SIM = obj_dir/Vtb_decode_stage

all: run

$(SIM): all.f $(wildcard verilog/*.sv bench/*.sv)
	verilator --binary --timing --assert -f all.f --top-module tb_decode_stage

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --top-module decode_stage \
		verilog/rv_isa_pkg.sv verilog/pipe_ctrl_pkg.sv \
		verilog/control_decode.sv verilog/operand_forward.sv \
		verilog/execute_latch.sv verilog/decode_stage.sv

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* all.f */
verilog/rv_isa_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/control_decode.sv
verilog/operand_forward.sv
verilog/execute_latch.sv
verilog/decode_stage.sv
bench/decode_checker.sv
bench/tb_decode_stage.sv

/* bench/decode_checker.sv */
`timescale 1ns/1ns

module decode_checker (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [31:0]                        instr,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs1_addr,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs2_addr,
    input  logic [rv_isa_pkg::xlen-1:0]        rs1_data,
    input  logic [rv_isa_pkg::xlen-1:0]        rs2_data,
    input  logic [rv_isa_pkg::xlen-1:0]        alu_fwd,
    input  pipe_ctrl_pkg::exec_bundle_t        exec,
    output int unsigned                        err_count,
    output int unsigned                        check_count
);

    pipe_ctrl_pkg::exec_bundle_t        exp_b;             // due after the next edge
    string                              exp_test;
    string                              test;
    logic                               have_exp = 1'b0;
    logic [rv_isa_pkg::reg_addr_w-1:0]  prev_rd;           // model's rd in execute
    logic [rv_isa_pkg::reg_addr_w-1:0]  exp_rs1;
    logic [rv_isa_pkg::reg_addr_w-1:0]  exp_rs2;
    int unsigned                        errors = 0;
    int unsigned                        checks = 0;

    assign err_count   = errors;
    assign check_count = checks;

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s %s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    // funct3 / bit 30 table, sub only in register form
    function automatic pipe_ctrl_pkg::alu_op_e alu_for_funct3(input logic [2:0] f3,
                                                             input logic b30,
                                                             input logic reg_form);
        case (f3)
            3'd0:    return (b30 && reg_form) ? pipe_ctrl_pkg::alu_sub : pipe_ctrl_pkg::alu_add;
            3'd1:    return pipe_ctrl_pkg::alu_sll;
            3'd2:    return pipe_ctrl_pkg::alu_slt;
            3'd3:    return pipe_ctrl_pkg::alu_sltu;
            3'd4:    return pipe_ctrl_pkg::alu_xor;
            3'd5:    return b30 ? pipe_ctrl_pkg::alu_sra : pipe_ctrl_pkg::alu_srl;
            3'd6:    return pipe_ctrl_pkg::alu_or;
            default: return pipe_ctrl_pkg::alu_and;
        endcase
    endfunction

    // expected bundle and register addresses for one word
    task automatic predict_bundle(input logic [31:0] w, input logic [31:0] d1,
                                  input logic [31:0] d2, input logic [31:0] fwd,
                                  input logic [4:0] prev,
                                  output pipe_ctrl_pkg::exec_bundle_t b,
                                  output logic [4:0] a1, output logic [4:0] a2,
                                  output string name);
        logic        u1;
        logic        u2;
        logic        bad;
        logic [31:0] v1;
        logic [31:0] v2;
        b    = pipe_ctrl_pkg::bubble_bundle;
        u1   = 1'b0;
        u2   = 1'b0;
        bad  = 1'b0;
        name = "bubble";
        case (w[6:0])
            rv_isa_pkg::opc_load: begin
                name     = "load";
                u1       = 1'b1;
                b.rd     = w[11:7];
                b.alu_b  = {{20{w[31]}}, w[31:20]};       // I immediate
                b.alu_op = pipe_ctrl_pkg::alu_add;
                b.mem_op = pipe_ctrl_pkg::mem_load;
                b.wb_en  = 1'b1;
                case (w[14:12])
                    3'd0:    b.wb_type = pipe_ctrl_pkg::wb_byte_s;
                    3'd1:    b.wb_type = pipe_ctrl_pkg::wb_half_s;
                    3'd2:    b.wb_type = pipe_ctrl_pkg::wb_word;
                    3'd4:    b.wb_type = pipe_ctrl_pkg::wb_byte_u;
                    3'd5:    b.wb_type = pipe_ctrl_pkg::wb_half_u;
                    default: bad = 1'b1;
                endcase
            end
            rv_isa_pkg::opc_store: begin
                name     = "store";
                u1       = 1'b1;
                u2       = 1'b1;
                b.alu_b  = {{20{w[31]}}, w[31:25], w[11:7]};  // S immediate
                b.alu_op = pipe_ctrl_pkg::alu_add;
                b.mem_op = pipe_ctrl_pkg::mem_store;
                case (w[14:12])  // access width
                    3'd0:    b.wb_type = pipe_ctrl_pkg::wb_byte_s;
                    3'd1:    b.wb_type = pipe_ctrl_pkg::wb_half_s;
                    3'd2:    b.wb_type = pipe_ctrl_pkg::wb_word;
                    default: bad = 1'b1;
                endcase
            end
            rv_isa_pkg::opc_op_imm: begin
                name          = "alu_imm";
                u1            = 1'b1;
                b.rd          = w[11:7];
                b.alu_b       = {{20{w[31]}}, w[31:20]};
                b.alu_op      = alu_for_funct3(w[14:12], w[30], 1'b0);
                b.wb_en       = 1'b1;
                b.wb_from_alu = 1'b1;
            end
            rv_isa_pkg::opc_op: begin
                name          = "alu_reg";
                u1            = 1'b1;
                u2            = 1'b1;
                b.rd          = w[11:7];
                b.alu_op      = alu_for_funct3(w[14:12], w[30], 1'b1);
                b.wb_en       = 1'b1;
                b.wb_from_alu = 1'b1;
            end
            rv_isa_pkg::opc_bubble: ;
            default: bad = 1'b1;
        endcase
        if (bad) begin  // marked empty slot, reads nothing
            b         = pipe_ctrl_pkg::bubble_bundle;
            b.illegal = 1'b1;
            u1        = 1'b0;
            u2        = 1'b0;
            name      = "illegal";
        end
        v1 = (u1 && w[19:15] == prev && w[19:15] != 5'd0) ? fwd : d1;
        v2 = (u2 && w[24:20] == prev && w[24:20] != 5'd0) ? fwd : d2;
        if ((v1 !== d1 && u1) || (v2 !== d2 && u2)) name = {name, "+fwd"};
        if (u1) b.alu_a = v1;
        if (w[6:0] == rv_isa_pkg::opc_op && !bad) b.alu_b = v2;
        if (b.mem_op == pipe_ctrl_pkg::mem_store) b.store_data = v2;
        a1 = u1 ? w[19:15] : 5'd0;  // unused address reads x0
        a2 = u2 ? w[24:20] : 5'd0;
    endtask

    // inputs and exec are both settled at the falling edge
    always @(negedge clk) begin
        if (have_exp) begin
            compare_field(exp_test, "rd", 32'(exp_b.rd), 32'(exec.rd));
            compare_field(exp_test, "alu_a", exp_b.alu_a, exec.alu_a);
            compare_field(exp_test, "alu_b", exp_b.alu_b, exec.alu_b);
            compare_field(exp_test, "alu_op", 32'(exp_b.alu_op), 32'(exec.alu_op));
            compare_field(exp_test, "mem_op", 32'(exp_b.mem_op), 32'(exec.mem_op));
            compare_field(exp_test, "wb_from_alu", 32'(exp_b.wb_from_alu), 32'(exec.wb_from_alu));
            compare_field(exp_test, "wb_en", 32'(exp_b.wb_en), 32'(exec.wb_en));
            compare_field(exp_test, "wb_type", 32'(exp_b.wb_type), 32'(exec.wb_type));
            compare_field(exp_test, "store_data", exp_b.store_data, exec.store_data);
            compare_field(exp_test, "illegal", 32'(exp_b.illegal), 32'(exec.illegal));
        end
        // only a real register write is a forwarding source
        prev_rd = (have_exp && exp_b.wb_en && exp_b.rd != 5'd0) ? exp_b.rd : 5'd0;
        if (!rst_n) begin
            exp_b    = pipe_ctrl_pkg::bubble_bundle;
            exp_test = "reset";
        end else begin
            predict_bundle(instr, rs1_data, rs2_data, alu_fwd, prev_rd,
                           exp_b, exp_rs1, exp_rs2, test);
            exp_test = test;
            compare_field(test, "rs1_addr", 32'(exp_rs1), 32'(rs1_addr));
            compare_field(test, "rs2_addr", 32'(exp_rs2), 32'(rs2_addr));
        end
        have_exp = 1'b1;
    end

endmodule

/* bench/tb_decode_stage.sv */
`timescale 1ns/1ns

module tb_decode_stage;

    localparam int unsigned n_instr      = 2000;
    localparam int unsigned reset_cycles = 3;
    localparam int unsigned max_cycles   = n_instr + reset_cycles + 100;  // generous drain margin

    logic                               clk = 1'b0;
    logic                               rst_n;
    rv_isa_pkg::instr_u                 instr;
    logic [rv_isa_pkg::xlen-1:0]        rs1_data;
    logic [rv_isa_pkg::xlen-1:0]        rs2_data;
    logic [rv_isa_pkg::xlen-1:0]        alu_fwd;
    logic [rv_isa_pkg::reg_addr_w-1:0]  rs1_addr;
    logic [rv_isa_pkg::reg_addr_w-1:0]  rs2_addr;
    pipe_ctrl_pkg::exec_bundle_t        exec;

    logic [rv_isa_pkg::xlen-1:0]        regs [32];  // register file model
    int unsigned                        cycles = 0;
    int unsigned                        err_count;
    int unsigned                        check_count;

    always #10 clk = ~clk;  // 20 ns period

    // register file answers in the same cycle
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    decode_stage UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .alu_fwd  (alu_fwd),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .exec     (exec)
    );

    decode_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_fwd     (alu_fwd),
        .exec        (exec),
        .err_count   (err_count),
        .check_count (check_count)
    );

    // mostly x0..x3 so back-to-back hazards show up often
    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        if ($urandom_range(3, 0) != 0) r = 5'($urandom_range(3, 0));
        else r = 5'($urandom());
        return r;
    endfunction

    // load, store, op-imm and op get 3 of 16 each and bubble and illegal 2 each
    function automatic logic [31:0] random_instr();
        int unsigned kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [31:0] w;
        kind = $urandom_range(15, 0);
        w    = $urandom();
        if (kind < 3) begin
            case ($urandom_range(4, 0))  // lb lh lw lbu lhu
                0:       f3 = 3'd0;
                1:       f3 = 3'd1;
                2:       f3 = 3'd2;
                3:       f3 = 3'd4;
                default: f3 = 3'd5;
            endcase
            w = {w[31:20], pick_reg(), f3, pick_reg(), rv_isa_pkg::opc_load};
        end else if (kind < 6) begin
            f3 = 3'($urandom_range(2, 0));  // sb sh sw
            w  = {w[31:25], pick_reg(), pick_reg(), f3, w[11:7], rv_isa_pkg::opc_store};
        end else if (kind < 9) begin
            f3 = 3'($urandom());
            f7 = w[31:25];
            if (f3 == rv_isa_pkg::f3_sll) f7 = 7'h00;                    // slli
            else if (f3 == rv_isa_pkg::f3_srl) f7 = w[30] ? 7'h20 : 7'h00;  // srai / srli
            w = {f7, w[24:20], pick_reg(), f3, pick_reg(), rv_isa_pkg::opc_op_imm};
        end else if (kind < 12) begin
            f3 = 3'($urandom());
            f7 = ((f3 == rv_isa_pkg::f3_add || f3 == rv_isa_pkg::f3_srl) && w[30]) ? 7'h20 : 7'h00;
            w  = {f7, pick_reg(), pick_reg(), f3, pick_reg(), rv_isa_pkg::opc_op};
        end else if (kind < 14) begin
            w = '0;  // bubble
        end else begin
            case ($urandom_range(2, 0))
                0: begin  // load with funct3 3, 6 or 7
                    f3 = ($urandom_range(2, 0) == 0) ? 3'd3 : {2'b11, w[0]};
                    w  = {w[31:15], f3, w[11:7], rv_isa_pkg::opc_load};
                end
                1: begin  // store wider than a word
                    f3 = 3'($urandom_range(7, 3));
                    w  = {w[31:15], f3, w[11:7], rv_isa_pkg::opc_store};
                end
                default: begin  // opcode outside the supported set
                    opc = w[6:0];
                    if (opc == rv_isa_pkg::opc_load || opc == rv_isa_pkg::opc_store
                        || opc == rv_isa_pkg::opc_op_imm || opc == rv_isa_pkg::opc_op
                        || opc == rv_isa_pkg::opc_bubble) begin
                        opc = opc ^ 7'h40;  // lands on branch, madd etc
                    end
                    w[6:0] = opc;
                end
            endcase
        end
        return w;
    endfunction

    initial begin
        void'($urandom(32'h6a51));
        rst_n   <= 1'b0;
        instr   <= random_instr();  // random words in reset must not reach exec
        alu_fwd <= $urandom();
        for (int i = 0; i < 32; i++) begin
            regs[i] <= (i == 0) ? '0 : $urandom();
        end
        repeat (reset_cycles - 1) begin
            @(posedge clk);
            instr   <= random_instr();
            alu_fwd <= $urandom();
        end
        @(posedge clk);
        rst_n   <= 1'b1;
        instr   <= '0;                  // first slot after reset stays empty
        alu_fwd <= $urandom();
        for (int n = 0; n < n_instr; n++) begin
            @(posedge clk);
            instr   <= random_instr();
            alu_fwd <= $urandom();
            regs[5'($urandom_range(31, 1))] <= $urandom();  // register file keeps changing
        end
        @(posedge clk);
        instr <= '0;
        repeat (3) @(posedge clk);  // last bundle is latched and compared
        $display("checks %0d errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout, the run was still going after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

/* verilog/control_decode.sv */
`timescale 1ns/1ns

module control_decode (
    input  rv_isa_pkg::instr_u                  instr,
    output logic [rv_isa_pkg::reg_addr_w-1:0]   rs1_addr,
    output logic [rv_isa_pkg::reg_addr_w-1:0]   rs2_addr,
    output pipe_ctrl_pkg::dec_t                 dec
);

    logic bad;  // unknown opcode or funct3

    // funct3 plus instr[30] to alu op, SUB only exists in register form
    function automatic pipe_ctrl_pkg::alu_op_e alu_decode(
        input logic [2:0] f3,
        input logic       alt,
        input logic       reg_form
    );
        pipe_ctrl_pkg::alu_op_e op;
        case (f3)
            rv_isa_pkg::f3_add:  op = (alt && reg_form) ? pipe_ctrl_pkg::alu_sub
                                                        : pipe_ctrl_pkg::alu_add;
            rv_isa_pkg::f3_sll:  op = pipe_ctrl_pkg::alu_sll;
            rv_isa_pkg::f3_slt:  op = pipe_ctrl_pkg::alu_slt;
            rv_isa_pkg::f3_sltu: op = pipe_ctrl_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:  op = pipe_ctrl_pkg::alu_xor;
            rv_isa_pkg::f3_srl:  op = alt ? pipe_ctrl_pkg::alu_sra
                                          : pipe_ctrl_pkg::alu_srl;
            rv_isa_pkg::f3_or:   op = pipe_ctrl_pkg::alu_or;
            default:             op = pipe_ctrl_pkg::alu_and;  // f3_and, all 8 codes used
        endcase
        return op;
    endfunction

    always_comb begin
        dec = pipe_ctrl_pkg::dec_idle;  // start from an empty slot
        bad = 1'b0;

        case (instr.r.opcode)
            rv_isa_pkg::opc_load: begin
                dec.rd          = instr.i.rd;
                dec.rs1         = instr.i.rs1;
                dec.uses_rs1    = 1'b1;
                dec.imm         = {{(rv_isa_pkg::xlen-12){instr.i.imm[11]}}, instr.i.imm};
                dec.alu_op      = pipe_ctrl_pkg::alu_add;  // address = rs1 + imm
                dec.mem_op      = pipe_ctrl_pkg::mem_load;
                dec.wb_en       = 1'b1;
                dec.wb_from_alu = 1'b0;                    // data comes from memory
                case (instr.i.funct3)
                    rv_isa_pkg::f3_lb:  dec.wb_type = pipe_ctrl_pkg::wb_byte_s;
                    rv_isa_pkg::f3_lh:  dec.wb_type = pipe_ctrl_pkg::wb_half_s;
                    rv_isa_pkg::f3_lw:  dec.wb_type = pipe_ctrl_pkg::wb_word;
                    rv_isa_pkg::f3_lbu: dec.wb_type = pipe_ctrl_pkg::wb_byte_u;
                    rv_isa_pkg::f3_lhu: dec.wb_type = pipe_ctrl_pkg::wb_half_u;
                    default:            bad = 1'b1;
                endcase
            end

            rv_isa_pkg::opc_store: begin
                dec.rs1      = instr.s.rs1;
                dec.rs2      = instr.s.rs2;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;                       // store data
                dec.imm      = {{(rv_isa_pkg::xlen-12){instr.s.imm_hi[6]}},
                                instr.s.imm_hi, instr.s.imm_lo};
                dec.alu_op   = pipe_ctrl_pkg::alu_add;
                dec.mem_op   = pipe_ctrl_pkg::mem_store;   // no rd, no write-back
                case (instr.s.funct3)
                    rv_isa_pkg::f3_sb: dec.wb_type = pipe_ctrl_pkg::wb_byte_s;
                    rv_isa_pkg::f3_sh: dec.wb_type = pipe_ctrl_pkg::wb_half_s;
                    rv_isa_pkg::f3_sw: dec.wb_type = pipe_ctrl_pkg::wb_word;
                    default:           bad = 1'b1;
                endcase
            end

            rv_isa_pkg::opc_op_imm: begin
                dec.rd          = instr.i.rd;
                dec.rs1         = instr.i.rs1;
                dec.uses_rs1    = 1'b1;
                dec.imm         = {{(rv_isa_pkg::xlen-12){instr.i.imm[11]}}, instr.i.imm};
                dec.alu_op      = alu_decode(instr.i.funct3, instr.r.funct7[5], 1'b0);
                dec.wb_en       = 1'b1;
                dec.wb_from_alu = 1'b1;
            end

            rv_isa_pkg::opc_op: begin
                dec.rd          = instr.r.rd;
                dec.rs1         = instr.r.rs1;
                dec.rs2         = instr.r.rs2;
                dec.uses_rs1    = 1'b1;
                dec.uses_rs2    = 1'b1;
                dec.alu_op      = alu_decode(instr.r.funct3, instr.r.funct7[5], 1'b1);
                dec.wb_en       = 1'b1;
                dec.wb_from_alu = 1'b1;
            end

            rv_isa_pkg::opc_bubble: begin
                // empty slot, idle fields stand
            end

            default: bad = 1'b1;  // LUI, JAL, branches etc land here too
        endcase

        // an illegal word passes down as a marked bubble
        if (bad) begin
            dec         = pipe_ctrl_pkg::dec_idle;
            dec.illegal = 1'b1;
        end
    end

    assign rs1_addr = dec.rs1;  // zero unless used
    assign rs2_addr = dec.rs2;

    // a marked word must not reach the register file or memory
    always_comb begin
        if (dec.illegal) begin
            assert (!dec.wb_en && dec.mem_op == pipe_ctrl_pkg::mem_nop
                    && rs1_addr == '0 && rs2_addr == '0)
                else $error("illegal word decoded with live control");
        end
    end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  rv_isa_pkg::instr_u                 instr,
    input  logic [rv_isa_pkg::xlen-1:0]        rs1_data,   // from the register file
    input  logic [rv_isa_pkg::xlen-1:0]        rs2_data,
    input  logic [rv_isa_pkg::xlen-1:0]        alu_fwd,    // execute result, same cycle
    output logic [rv_isa_pkg::reg_addr_w-1:0]  rs1_addr,
    output logic [rv_isa_pkg::reg_addr_w-1:0]  rs2_addr,
    output pipe_ctrl_pkg::exec_bundle_t        exec
);

    pipe_ctrl_pkg::dec_t                dec;          // decoded fields
    pipe_ctrl_pkg::exec_bundle_t        next_bundle;  // bundle before the register
    logic [rv_isa_pkg::reg_addr_w-1:0]  prev_rd;      // hazard source, back from the latch

    control_decode u_control_decode (
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .dec      (dec)
    );

    operand_forward u_operand_forward (
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_fwd     (alu_fwd),
        .prev_rd     (prev_rd),
        .next_bundle (next_bundle)
    );

    execute_latch u_execute_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .next_bundle (next_bundle),
        .exec        (exec),
        .prev_rd     (prev_rd)
    );

endmodule

/* verilog/execute_latch.sv */
`timescale 1ns/1ns

module execute_latch (
    input  logic                               clk,
    input  logic                               rst_n,
    input  pipe_ctrl_pkg::exec_bundle_t        next_bundle,
    output pipe_ctrl_pkg::exec_bundle_t        exec,
    output logic [rv_isa_pkg::reg_addr_w-1:0]  prev_rd
);

    // decode/execute pipeline register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec <= pipe_ctrl_pkg::bubble_bundle;  // empty slot
        end else begin
            exec <= next_bundle;                   // no stall, a new word every edge
        end
    end

    // rd of the instruction now in execute, but only if it really writes
    // a register; stores, bubbles and marked words give zero
    assign prev_rd = (exec.wb_en && (exec.rd != '0)) ? exec.rd : '0;

    // stores carry no destination
    store_no_wb: assert property (
        @(posedge clk) disable iff (!rst_n)
        (exec.mem_op == pipe_ctrl_pkg::mem_store) |-> !exec.wb_en
    ) else $error("store bundle with wb_en set");

    // load data comes from memory, never the alu
    load_wb_mem: assert property (
        @(posedge clk) disable iff (!rst_n)
        (exec.mem_op == pipe_ctrl_pkg::mem_load) |-> !exec.wb_from_alu
    ) else $error("load bundle selects alu write-back");

endmodule

/* verilog/operand_forward.sv */
`timescale 1ns/1ns

module operand_forward (
    input  pipe_ctrl_pkg::dec_t                dec,
    input  logic [rv_isa_pkg::xlen-1:0]        rs1_data,
    input  logic [rv_isa_pkg::xlen-1:0]        rs2_data,
    input  logic [rv_isa_pkg::xlen-1:0]        alu_fwd,    // result now in execute
    input  logic [rv_isa_pkg::reg_addr_w-1:0]  prev_rd,    // zero when nothing to forward
    output pipe_ctrl_pkg::exec_bundle_t        next_bundle
);

    logic                        fwd_rs1;
    logic                        fwd_rs2;
    logic [rv_isa_pkg::xlen-1:0] rs1_val;
    logic [rv_isa_pkg::xlen-1:0] rs2_val;
    logic                        reg_form;  // OP, alu_b from rs2

    // one-cycle raw hazard, x0 is hardwired and never forwarded
    assign fwd_rs1 = dec.uses_rs1 && (dec.rs1 == prev_rd) && (|dec.rs1);
    assign fwd_rs2 = dec.uses_rs2 && (dec.rs2 == prev_rd) && (|dec.rs2);

    assign rs1_val = fwd_rs1 ? alu_fwd : rs1_data;
    assign rs2_val = fwd_rs2 ? alu_fwd : rs2_data;

    // stores read rs2 too, but only as data
    assign reg_form = dec.uses_rs2 && (dec.mem_op == pipe_ctrl_pkg::mem_nop);

    always_comb begin
        next_bundle.rd          = dec.rd;
        next_bundle.alu_a       = dec.uses_rs1 ? rs1_val : '0;  // zero in a bubble
        next_bundle.alu_b       = reg_form ? rs2_val : dec.imm;
        next_bundle.alu_op      = dec.alu_op;
        next_bundle.mem_op      = dec.mem_op;
        next_bundle.wb_from_alu = dec.wb_from_alu;
        next_bundle.wb_en       = dec.wb_en;
        next_bundle.wb_type     = dec.wb_type;
        next_bundle.store_data  = (dec.mem_op == pipe_ctrl_pkg::mem_store) ? rs2_val : '0;
        next_bundle.illegal     = dec.illegal;
    end

    // an unused source leaves no trace in the operands
    always_comb begin
        if (!dec.uses_rs1) begin
            assert (next_bundle.alu_a == '0)
                else $error("rs1 unused but alu_a is live");
        end
        if (!dec.uses_rs2) begin
            assert (next_bundle.store_data == '0 && next_bundle.alu_b == dec.imm)
                else $error("rs2 unused but feeds an operand");
        end
    end

endmodule

/* verilog/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    // alu operation, nop is zero so an empty slot is all-zero
    typedef enum logic [3:0] {
        alu_nop  = 4'd0,
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_nop   = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

    // width and extension of the memory access, loads and stores alike
    typedef enum logic [2:0] {
        wb_word   = 3'd0,
        wb_half_s = 3'd1,
        wb_half_u = 3'd2,
        wb_byte_s = 3'd3,
        wb_byte_u = 3'd4
    } wb_type_e;

    // what the execute stage gets each cycle
    typedef struct packed {
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
        logic [rv_isa_pkg::xlen-1:0]       alu_a;
        logic [rv_isa_pkg::xlen-1:0]       alu_b;
        alu_op_e                           alu_op;
        mem_op_e                           mem_op;
        logic                              wb_from_alu;  // 0 = write back from memory
        logic                              wb_en;
        wb_type_e                          wb_type;
        logic [rv_isa_pkg::xlen-1:0]       store_data;
        logic                              illegal;
    } exec_bundle_t;

    // decoded control, before the register data is known
    typedef struct packed {
        logic [rv_isa_pkg::reg_addr_w-1:0] rd;
        alu_op_e                           alu_op;
        mem_op_e                           mem_op;
        logic                              wb_from_alu;
        logic                              wb_en;
        wb_type_e                          wb_type;
        logic                              illegal;
        logic                              uses_rs1;
        logic                              uses_rs2;
        logic [rv_isa_pkg::reg_addr_w-1:0] rs1;
        logic [rv_isa_pkg::reg_addr_w-1:0] rs2;
        logic [rv_isa_pkg::xlen-1:0]       imm;  // already sign-extended
    } dec_t;

    localparam exec_bundle_t bubble_bundle = '{
        rd: '0, alu_a: '0, alu_b: '0, alu_op: alu_nop, mem_op: mem_nop,
        wb_from_alu: 1'b0, wb_en: 1'b0, wb_type: wb_word, store_data: '0,
        illegal: 1'b0
    };

    // decode fields of an empty slot
    localparam dec_t dec_idle = '{
        rd: '0, alu_op: alu_nop, mem_op: mem_nop, wb_from_alu: 1'b0,
        wb_en: 1'b0, wb_type: wb_word, illegal: 1'b0, uses_rs1: 1'b0,
        uses_rs2: 1'b0, rs1: '0, rs2: '0, imm: '0
    };

endpackage

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen       = 32;  // data word width
    localparam int reg_addr_w = 5;   // x0..x31

    // major opcodes, bits [6:0]
    localparam logic [6:0] opc_load   = 7'b000_0011;  // LB LH LW LBU LHU
    localparam logic [6:0] opc_store  = 7'b010_0011;  // SB SH SW
    localparam logic [6:0] opc_op_imm = 7'b001_0011;  // ADDI .. SRAI
    localparam logic [6:0] opc_op     = 7'b011_0011;  // ADD .. AND
    localparam logic [6:0] opc_bubble = 7'b000_0000;  // all-zero word, empty slot

    // load / store widths
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    // alu functions, shared by OP and OP-IMM
    localparam logic [2:0] f3_add  = 3'b000;  // also SUB when bit 30 set (OP only)
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;  // SRA when bit 30 set
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    typedef struct packed {
        logic [6:0]            funct7;  // bit 5 is instr[30], the alt-op select
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_hi;  // imm[11:5]
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;  // imm[4:0], sits where rd would be
        logic [6:0]            opcode;
    } s_type_t;

    // one instruction word, three views of the same bits
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
    } instr_u;

endpackage
